// ==== include/game_defs.svh ====
`ifndef GAME_DEFS_SVH
`define GAME_DEFS_SVH

// ####################
// Matrix geometry
// ####################
`define ROW_W 8
`define ROWS 8

// ####################
// Timing
// ####################
// Cycles a synced pin must hold its new value before the filtered level follows
`define DEBOUNCE_CYCLES 16
// Cycles between two background scroll steps
`define SPEED_TICKS 6000
// System cycles per half period of max7219_clk
`define SPI_HALF 2
// Cycles with ncs high between two words
`define SPI_GAP 4

// ####################
// Display and game start values
// ####################
`define INTENSITY 4'hA
`define DOT_INIT_ROW 0
`define DOT_INIT_COL 4
// Listed from row 7 down to row 0
`define BG_INIT {8'b11100000, 8'h00, 8'h00, 8'b11100000, 8'h00, 8'b11100000, 8'h00, 8'h00}

`endif

// ==== source/game_pkg.sv ====
`include "game_defs.svh"

package game_pkg;

	// One matrix row, bit 7 is the leftmost LED
	typedef logic [`ROW_W-1:0] row_t;

	// Whole 8x8 layer, element i is row i
	typedef row_t [`ROWS-1:0] frame_t;

	// MAX7219 register addresses
	typedef enum logic [3:0] {
		reg_digit_1      = 4'h1,
		reg_digit_2      = 4'h2,
		reg_digit_3      = 4'h3,
		reg_digit_4      = 4'h4,
		reg_digit_5      = 4'h5,
		reg_digit_6      = 4'h6,
		reg_digit_7      = 4'h7,
		reg_digit_8      = 4'h8,
		reg_decode_mode  = 4'h9,
		reg_intensity    = 4'hA,
		reg_scan_limit   = 4'hB,
		reg_shutdown     = 4'hC,
		reg_display_test = 4'hF
	} max_reg_t;

	// Serial word engine states
	typedef enum logic [1:0] {
		spi_idle,
		spi_shift,
		spi_gap
	} spi_state_t;

endpackage

// ==== source/button_if.sv ====
// Debounced press pulses, each high for exactly one clock
interface button_if;
	logic start_p;
	logic left_p;
	logic right_p;
	logic up_p;
	logic down_p;

	modport src (output start_p, left_p, right_p, up_p, down_p);

	modport sink (input start_p, left_p, right_p, up_p, down_p);
endinterface

// ==== source/button_debounce.sv ====
`include "game_defs.svh"

// Pin order in buttons_n: start, left, right, up, down (bit 4 down to bit 0)
module button_debounce (
	input  logic       clock_50,
	input  logic       rst,
	input  logic [4:0] buttons_n,
	button_if.src      btn
);

	localparam int cnt_w = $clog2(`DEBOUNCE_CYCLES + 1);
	localparam logic [cnt_w-1:0] cnt_last = cnt_w'(`DEBOUNCE_CYCLES - 1);

	logic [4:0]       sync_1;
	logic [4:0]       sync_2;
	logic [4:0]       level;
	logic [4:0]       level_q;
	logic [4:0]       press;
	logic [cnt_w-1:0] stable_cnt [0:4];

	// Two flop synchronizer, pins turned active high here
	always_ff @(posedge clock_50) begin
		if (rst) begin
			sync_1 <= '0;
			sync_2 <= '0;
		end else begin
			sync_1 <= ~buttons_n;
			sync_2 <= sync_1;
		end
	end

	// Level follows the synced pin only after a full run of disagreeing cycles
	always_ff @(posedge clock_50) begin
		if (rst) begin
			for (int i = 0; i < 5; i++) begin
				stable_cnt[i] <= '0;
			end
			level   <= '0;
			level_q <= '0;
		end else begin
			level_q <= level;
			for (int i = 0; i < 5; i++) begin
				if (sync_2[i] == level[i]) begin
					stable_cnt[i] <= '0;
				end else if (stable_cnt[i] == cnt_last) begin
					stable_cnt[i] <= '0;
					level[i]      <= sync_2[i];
				end else begin
					stable_cnt[i] <= stable_cnt[i] + 1'b1;
				end
			end
		end
	end

	// Rising edge of the filtered level is a press
	assign press = level & ~level_q;

	assign btn.start_p = press[4];
	assign btn.left_p  = press[3];
	assign btn.right_p = press[2];
	assign btn.up_p    = press[1];
	assign btn.down_p  = press[0];

endmodule

// ==== source/point_matrix.sv ====
`include "game_defs.svh"

module point_matrix import game_pkg::*; (
	input  logic    clock_50,
	input  logic    rst,
	button_if.sink  btn,
	output frame_t  point_rows
);

	localparam row_t init_row = row_t'(1) << `DOT_INIT_COL;

	frame_t rows_next;

	// ####################
	// Move logic
	// ####################
	// Only one move per pulse, left has the highest priority
	always_comb begin
		rows_next = point_rows;
		if (btn.left_p) begin
			// Every row one bit toward the MSB
			for (int i = 0; i < `ROWS; i++) begin
				rows_next[i] = {point_rows[i][`ROW_W-2:0], point_rows[i][`ROW_W-1]};
			end
		end else if (btn.right_p) begin
			for (int i = 0; i < `ROWS; i++) begin
				rows_next[i] = {point_rows[i][0], point_rows[i][`ROW_W-1:1]};
			end
		end else if (btn.up_p) begin
			// Row 7 wraps around to row 0
			for (int i = 0; i < `ROWS; i++) begin
				rows_next[(i + 1) % `ROWS] = point_rows[i];
			end
		end else if (btn.down_p) begin
			for (int i = 0; i < `ROWS; i++) begin
				rows_next[i] = point_rows[(i + 1) % `ROWS];
			end
		end
	end

	// ####################
	// Row registers
	// ####################
	always_ff @(posedge clock_50) begin
		if (rst) begin
			for (int i = 0; i < `ROWS; i++) begin
				point_rows[i] <= (i == `DOT_INIT_ROW) ? init_row : '0;
			end
		end else begin
			point_rows <= rows_next;
		end
	end

endmodule

// ==== source/background_matrix.sv ====
`include "game_defs.svh"

module background_matrix import game_pkg::*; (
	input  logic    clock_50,
	input  logic    rst,
	button_if.sink  btn,
	output frame_t  bg_rows
);

	localparam int tick_w = $clog2(`SPEED_TICKS);
	localparam logic [tick_w-1:0] tick_last = tick_w'(`SPEED_TICKS - 1);

	logic              running;
	logic [tick_w-1:0] tick_cnt;
	logic              step;

	// ####################
	// Run flag and prescaler
	// ####################
	// Once set only reset clears it, so later start presses do nothing
	always_ff @(posedge clock_50) begin
		if (rst) begin
			running <= 1'b0;
		end else if (btn.start_p) begin
			running <= 1'b1;
		end
	end

	// First step lands SPEED_TICKS cycles after running goes high
	always_ff @(posedge clock_50) begin
		if (rst) begin
			tick_cnt <= '0;
		end else if (running) begin
			if (step) begin
				tick_cnt <= '0;
			end else begin
				tick_cnt <= tick_cnt + 1'b1;
			end
		end
	end

	assign step = running && (tick_cnt == tick_last);

	// ####################
	// Obstacle rows
	// ####################
	// Scroll toward row 0, row 0 comes back in at row 7
	always_ff @(posedge clock_50) begin
		if (rst) begin
			bg_rows <= `BG_INIT;
		end else if (step) begin
			for (int i = 0; i < `ROWS; i++) begin
				bg_rows[i] <= bg_rows[(i + 1) % `ROWS];
			end
		end
	end

endmodule

// ==== source/matrix_display.sv ====
`include "game_defs.svh"

module matrix_display import game_pkg::*; (
	input  logic   clock_50,
	input  logic   rst,
	input  frame_t point_rows,
	input  frame_t bg_rows,
	output logic   max7219_din,
	output logic   max7219_ncs,
	output logic   max7219_clk
);

	localparam int word_bits = 16;
	localparam int cnt_max = (`SPI_GAP > `SPI_HALF) ? `SPI_GAP : `SPI_HALF;
	localparam int cnt_w = $clog2(cnt_max + 1);
	localparam logic [cnt_w-1:0] half_last = cnt_w'(`SPI_HALF - 1);
	localparam logic [cnt_w-1:0] gap_last = cnt_w'(`SPI_GAP - 1);
	localparam logic [3:0] bit_last = 4'(word_bits - 1);
	// Words 0 to 4 set the chip up, 5 to 12 are digit 1 to digit 8
	localparam logic [3:0] first_digit = 4'd5;
	localparam logic [3:0] last_word = 4'd12;

	spi_state_t       state;
	logic [3:0]       word_idx;
	logic [cnt_w-1:0] tick_cnt;
	logic [3:0]       bit_cnt;
	logic [15:0]      shreg;
	logic             load;
	logic             shift_edge;

	frame_t              merged;
	logic [2:0]          col;
	logic [`ROWS-1:0]    col_byte;
	max_reg_t            word_op;
	logic [7:0]          word_data;
	logic [15:0]         word;

	// ####################
	// Word builder
	// ####################
	assign col = 3'(word_idx - first_digit);

	always_comb begin
		for (int r = 0; r < `ROWS; r++) begin
			merged[r] = point_rows[r] | bg_rows[r];
		end
		// Row 0 ends up in bit 7 of the column byte
		for (int r = 0; r < `ROWS; r++) begin
			col_byte[`ROWS - 1 - r] = merged[r][`ROW_W - 1 - col];
		end
	end

	always_comb begin
		case (word_idx)
			4'd0: begin
				word_op   = reg_display_test;
				word_data = 8'h00;
			end
			4'd1: begin
				word_op   = reg_decode_mode;
				word_data = 8'h00;
			end
			4'd2: begin
				word_op   = reg_scan_limit;
				word_data = 8'h07;
			end
			4'd3: begin
				word_op   = reg_intensity;
				word_data = {4'h0, `INTENSITY};
			end
			4'd4: begin
				word_op   = reg_shutdown;
				word_data = 8'h01;
			end
			default: begin
				word_op   = max_reg_t'(word_idx - 4'd4);
				word_data = col_byte;
			end
		endcase
	end

	assign word = {4'h0, word_op, word_data};

	// ####################
	// Serial engine
	// ####################
	// A new word is taken right out of reset and at the end of every gap
	assign load = (state == spi_idle) || (state == spi_gap && tick_cnt == gap_last);
	// End of a high half period, the next bit goes out as the clock falls
	assign shift_edge = (state == spi_shift) && (tick_cnt == half_last) && max7219_clk;

	always_ff @(posedge clock_50) begin
		if (rst) begin
			state       <= spi_idle;
			word_idx    <= '0;
			tick_cnt    <= '0;
			bit_cnt     <= '0;
			max7219_ncs <= 1'b1;
			max7219_clk <= 1'b0;
			max7219_din <= 1'b0;
		end else if (load) begin
			state       <= spi_shift;
			tick_cnt    <= '0;
			bit_cnt     <= '0;
			max7219_ncs <= 1'b0;
			max7219_clk <= 1'b0;
			max7219_din <= word[15];
			word_idx    <= (word_idx == last_word) ? first_digit : word_idx + 1'b1;
		end else begin
			case (state)
				spi_shift: begin
					if (tick_cnt == half_last) begin
						tick_cnt    <= '0;
						max7219_clk <= ~max7219_clk;
						if (shift_edge) begin
							if (bit_cnt == bit_last) begin
								// Last rising edge done, ncs high latches the word
								state       <= spi_gap;
								max7219_ncs <= 1'b1;
								max7219_din <= 1'b0;
							end else begin
								bit_cnt     <= bit_cnt + 1'b1;
								max7219_din <= shreg[15];
							end
						end
					end else begin
						tick_cnt <= tick_cnt + 1'b1;
					end
				end
				spi_gap: begin
					tick_cnt <= tick_cnt + 1'b1;
				end
				default: begin
					state <= spi_idle;
				end
			endcase
		end
	end

	// Holds the bits still to send, MSB next
	always_ff @(posedge clock_50) begin
		if (load) begin
			shreg <= {word[14:0], 1'b0};
		end else if (shift_edge) begin
			shreg <= shreg << 1;
		end
	end

endmodule

// ==== source/game_top.sv ====
module game_top import game_pkg::*; (
	input  logic clock_50,
	input  logic rst,
	input  logic start_n,
	input  logic left_n,
	input  logic right_n,
	input  logic up_n,
	input  logic down_n,
	output logic max7219_din,
	output logic max7219_ncs,
	output logic max7219_clk
);

	frame_t point_rows;
	frame_t bg_rows;

	button_if btn_bus ();

	// ####################
	// Inputs
	// ####################
	button_debounce button_debounce_u0 (
		.clock_50  (clock_50),
		.rst       (rst),
		.buttons_n ({start_n, left_n, right_n, up_n, down_n}),
		.btn       (btn_bus.src)
	);

	// ####################
	// Game layers
	// ####################
	point_matrix point_matrix_u0 (
		.clock_50   (clock_50),
		.rst        (rst),
		.btn        (btn_bus.sink),
		.point_rows (point_rows)
	);

	background_matrix background_matrix_u0 (
		.clock_50 (clock_50),
		.rst      (rst),
		.btn      (btn_bus.sink),
		.bg_rows  (bg_rows)
	);

	// ####################
	// LED matrix output
	// ####################
	matrix_display matrix_display_u0 (
		.clock_50    (clock_50),
		.rst         (rst),
		.point_rows  (point_rows),
		.bg_rows     (bg_rows),
		.max7219_din (max7219_din),
		.max7219_ncs (max7219_ncs),
		.max7219_clk (max7219_clk)
	);

endmodule

// ==== verif/game_tb.sv ====
`include "game_defs.svh"

module game_tb import game_pkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int clk_period = 100;
	localparam int n_moves = 40;
	localparam int n_glitches = 20;
	localparam int n_run_moves = 12;
	localparam int hold_max = `DEBOUNCE_CYCLES + 16;
	localparam int gap_max = 20 + 511;
	localparam longint press_max = hold_max + gap_max;
	localparam longint word_cycles = 32 * `SPI_HALF + `SPI_GAP;
	// Setup plus first frame, then one frame after each of three phases
	localparam longint plan_words = 13 + 3 * 9;
	localparam longint stim_cycles =
		(n_moves + n_glitches + n_run_moves + 2) * press_max + 4 * `SPEED_TICKS + 10;
	localparam longint limit_cycles = plan_words * word_cycles + stim_cycles + 2000;

	logic       clock_50;
	logic       rst;
	// start, left, right, up, down from bit 4 down to bit 0
	logic [4:0] pins_n;
	logic       max7219_din;
	logic       max7219_ncs;
	logic       max7219_clk;

	logic [31:0] lfsr_state;
	int          errors;
	int          checks;
	int          word_count;
	int          bit_count;
	logic [15:0] rx_word;
	// Latest data byte received for each digit register
	logic [7:0]  rx_digit [0:7];
	string       phase_name;
	frame_t      frame_q [$];
	frame_t      prev_frame;
	frame_t      dot_before;
	frame_t      hold_frame;

	// Reference model state
	logic [4:0] m_sync1;
	logic [4:0] m_sync2;
	logic [4:0] m_level;
	logic [4:0] m_level_q;
	logic [4:0] m_press;
	int         m_cnt [0:4];
	frame_t     m_point;
	frame_t     m_bg;
	frame_t     m_next;
	logic       m_running;
	int         m_tick;

	game_top dut0 (
		.clock_50    (clock_50),
		.rst         (rst),
		.start_n     (pins_n[4]),
		.left_n      (pins_n[3]),
		.right_n     (pins_n[2]),
		.up_n        (pins_n[1]),
		.down_n      (pins_n[0]),
		.max7219_din (max7219_din),
		.max7219_ncs (max7219_ncs),
		.max7219_clk (max7219_clk)
	);

	initial begin
		clock_50 = 1'b0;
		forever #(clk_period / 2) clock_50 = ~clock_50;
	end

	// ####################
	// Helpers
	// ####################
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		if (s[0]) begin
			return (s >> 1) ^ 32'h80200003;
		end
		return s >> 1;
	endfunction

	function automatic int unsigned rand_bits(input int n);
		int unsigned value;
		value = 0;
		for (int i = 0; i < n; i++) begin
			value = (value << 1) | lfsr_state[0];
			lfsr_state = lfsr_next(lfsr_state);
		end
		return value;
	endfunction

	// Column c of a frame, row 0 lands in bit 7
	function automatic logic [7:0] column_byte(input frame_t f, input int c);
		logic [7:0] b;
		for (int r = 0; r < `ROWS; r++) begin
			b[7 - r] = f[r][`ROW_W - 1 - c];
		end
		return b;
	endfunction

	function automatic logic [15:0] expected_word(input int n, input frame_t f);
		int d;
		case (n)
			0: return {4'h0, reg_display_test, 8'h00};
			1: return {4'h0, reg_decode_mode, 8'h00};
			2: return {4'h0, reg_scan_limit, 8'h07};
			3: return {4'h0, reg_intensity, 4'h0, `INTENSITY};
			4: return {4'h0, reg_shutdown, 8'h01};
			default: begin
				d = (n - 5) % 8 + 1;
				return {4'h0, 4'(d), column_byte(f, d - 1)};
			end
		endcase
	endfunction

	task automatic check_value(input string name, input logic [63:0] expected,
			input logic [63:0] actual);
		checks++;
		if (expected !== actual) begin
			errors++;
			$display("FAIL %s: expected %0h, actual %0h", name, expected, actual);
		end
	endtask

	task automatic drive_press(input int which, input int hold, input int gap);
		@(posedge clock_50);
		#5 pins_n[which] = 1'b0;
		repeat (hold) @(posedge clock_50);
		#5 pins_n[which] = 1'b1;
		repeat (gap) @(posedge clock_50);
	endtask

	task automatic press_random_move();
		int which;
		int hold;
		int gap;
		which = rand_bits(2);
		hold = `DEBOUNCE_CYCLES + 1 + rand_bits(4);
		gap = 20 + rand_bits(9);
		drive_press(which, hold, gap);
	endtask

	task automatic press_random_glitch();
		int which;
		int hold;
		int gap;
		which = rand_bits(2);
		hold = 1 + rand_bits(4) % (`DEBOUNCE_CYCLES - 1);
		gap = 20 + rand_bits(9);
		drive_press(which, hold, gap);
	endtask

	task automatic wait_words(input int target);
		wait (word_count >= target);
	endtask

	task automatic print_counts();
		$display("Checks: %0d, errors: %0d", checks, errors);
	endtask

	// ####################
	// Reference model
	// ####################
	always @(posedge clock_50) begin
		// Layers as they stand before this edge, taken if a word starts here
		for (int r = 0; r < `ROWS; r++) begin
			prev_frame[r] = m_point[r] | m_bg[r];
		end
		if (rst) begin
			m_sync1   = '0;
			m_sync2   = '0;
			m_level   = '0;
			m_level_q = '0;
			for (int i = 0; i < 5; i++) begin
				m_cnt[i] = 0;
			end
			m_point = '0;
			m_point[`DOT_INIT_ROW][`DOT_INIT_COL] = 1'b1;
			m_bg      = `BG_INIT;
			m_running = 1'b0;
			m_tick    = 0;
		end else begin
			m_press = m_level & ~m_level_q;
			m_next = m_point;
			if (m_press[3]) begin
				for (int r = 0; r < `ROWS; r++) begin
					m_next[r] = {m_point[r][`ROW_W-2:0], m_point[r][`ROW_W-1]};
				end
			end else if (m_press[2]) begin
				for (int r = 0; r < `ROWS; r++) begin
					m_next[r] = {m_point[r][0], m_point[r][`ROW_W-1:1]};
				end
			end else if (m_press[1]) begin
				for (int r = 0; r < `ROWS; r++) begin
					m_next[(r + 1) % `ROWS] = m_point[r];
				end
			end else if (m_press[0]) begin
				for (int r = 0; r < `ROWS; r++) begin
					m_next[r] = m_point[(r + 1) % `ROWS];
				end
			end
			m_point = m_next;
			// Background steps toward row 0 once per prescaler period
			if (m_running) begin
				if (m_tick == `SPEED_TICKS - 1) begin
					m_tick = 0;
					m_next = m_bg;
					for (int r = 0; r < `ROWS; r++) begin
						m_bg[r] = m_next[(r + 1) % `ROWS];
					end
				end else begin
					m_tick++;
				end
			end
			if (m_press[4]) begin
				m_running = 1'b1;
			end
			// A synced pin must disagree for a full run before the level follows
			m_level_q = m_level;
			for (int i = 0; i < 5; i++) begin
				if (m_sync2[i] == m_level[i]) begin
					m_cnt[i] = 0;
				end else if (m_cnt[i] + 1 == `DEBOUNCE_CYCLES) begin
					m_cnt[i]   = 0;
					m_level[i] = m_sync2[i];
				end else begin
					m_cnt[i]++;
				end
			end
			m_sync2 = m_sync1;
			m_sync1 = ~pins_n;
		end
	end

	// ####################
	// Word decoder
	// ####################
	always @(negedge max7219_ncs) begin
		bit_count = 0;
		rx_word = '0;
		frame_q.push_back(prev_frame);
	end

	always @(posedge max7219_clk) begin
		if (max7219_ncs === 1'b0) begin
			rx_word = {rx_word[14:0], max7219_din};
			bit_count++;
		end
	end

	always @(posedge max7219_ncs) begin
		frame_t f;
		if (frame_q.size() > 0) begin
			f = frame_q.pop_front();
			if (bit_count != 16) begin
				errors++;
				$display("ERROR: word %0d carried %0d clock pulses instead of 16",
					word_count, bit_count);
			end
			check_value($sformatf("%s word %0d", (word_count < 5) ? "setup" : phase_name,
				word_count), expected_word(word_count, f), rx_word);
			if (word_count >= 5) begin
				rx_digit[(word_count - 5) % 8] = rx_word[7:0];
			end
			word_count++;
		end
	end

	// ####################
	// Stimulus
	// ####################
	initial begin
		lfsr_state = 32'hc645;
		errors     = 0;
		checks     = 0;
		word_count = 0;
		bit_count  = 0;
		phase_name = "reset_frame";
		pins_n     = '1;
		rst        = 1'b1;
		repeat (2) @(posedge clock_50);
		#5 rst = 1'b0;
		wait_words(13);

		phase_name = "moves";
		repeat (n_moves) press_random_move();
		wait_words(word_count + 9);

		phase_name = "glitches";
		dot_before = m_point;
		repeat (n_glitches) press_random_glitch();
		wait_words(word_count + 9);
		// Background is still idle, so the display shows the old dot on BG_INIT
		hold_frame = dot_before | `BG_INIT;
		for (int c = 0; c < 8; c++) begin
			check_value($sformatf("glitch_dot_hold col %0d", c),
				column_byte(hold_frame, c), rx_digit[c]);
		end

		// Moves and a second start while the background runs
		phase_name = "scroll";
		drive_press(4, `DEBOUNCE_CYCLES + 4, 30);
		repeat (n_run_moves) press_random_move();
		repeat (2 * `SPEED_TICKS) @(posedge clock_50);
		drive_press(4, `DEBOUNCE_CYCLES + 4, 30);
		repeat (2 * `SPEED_TICKS) @(posedge clock_50);
		wait_words(word_count + 9);

		print_counts();
		if (errors == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

	initial begin
		#(limit_cycles * clk_period);
		errors++;
		$display("ERROR: watchdog expired after %0d cycles, display words stopped arriving",
			limit_cycles);
		print_counts();
		$display("** FAIL **");
		$finish;
	end

endmodule

// ==== vlog.f ====
+incdir+include
source/game_pkg.sv
source/button_if.sv
source/button_debounce.sv
source/point_matrix.sv
source/background_matrix.sv
source/matrix_display.sv
source/game_top.sv
verif/game_tb.sv
